// File: files.f
+incdir+source
source/aes_pkg.sv
source/aes_ctrl_pkg.sv
source/aes_sbox.sv
source/aes_inv_sbox.sv
source/aes_key_mem.sv
source/aes_encipher_block.sv
source/aes_decipher_block.sv
source/aes_core.sv
tests/aes_core_tb.sv

// File: source/aes_core.sv
module aes_core (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  aes_pkg::aes_req_t req_i,
    input  logic              on_i,
    output logic              ready_o,
    output aes_pkg::block_t   result_o,
    output logic              result_valid_o
);

    aes_ctrl_pkg::core_state_e state_reg;
    logic                      ready_reg;
    logic                      result_valid_reg;
    logic                      enc_sel_reg;  // encdec captured at the start

    logic            key_init;
    logic            key_ready;
    logic            eng_next;
    aes_pkg::block_t round_key;
    aes_pkg::word_t  key_sbox;

    logic            enc_next;
    aes_pkg::round_t enc_round;
    aes_pkg::block_t enc_block;
    logic            enc_ready;
    aes_pkg::word_t  enc_sbox;

    logic            dec_next;
    aes_pkg::round_t dec_round;
    aes_pkg::block_t dec_block;
    logic            dec_ready;

    aes_pkg::round_t muxed_round;
    aes_pkg::block_t muxed_block;
    logic            muxed_ready;
    aes_pkg::word_t  sbox_in;
    aes_pkg::word_t  sbox_out;

    aes_key_mem u_key_mem (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .key_i       (req_i.key),
        .init_i      (key_init),
        .round_i     (muxed_round),
        .round_key_o (round_key),
        .ready_o     (key_ready),
        .sbox_o      (key_sbox),
        .sbox_i      (sbox_out)
    );

    aes_encipher_block u_enc (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .next_i      (enc_next),
        .round_o     (enc_round),
        .round_key_i (round_key),
        .sbox_o      (enc_sbox),
        .sbox_i      (sbox_out),
        .block_i     (req_i.block),
        .new_block_o (enc_block),
        .ready_o     (enc_ready)
    );

    aes_decipher_block u_dec (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .next_i      (dec_next),
        .round_o     (dec_round),
        .round_key_i (round_key),
        .block_i     (req_i.block),
        .new_block_o (dec_block),
        .ready_o     (dec_ready)
    );

    aes_sbox u_sbox (
        .in_i  (sbox_in),
        .out_o (sbox_out)
    );

    assign key_init = (state_reg == aes_ctrl_pkg::CORE_IDLE) && on_i;
    assign eng_next = (state_reg == aes_ctrl_pkg::CORE_INIT) && key_ready;
    assign enc_next = eng_next && enc_sel_reg;
    assign dec_next = eng_next && !enc_sel_reg;
    assign sbox_in  = (state_reg == aes_ctrl_pkg::CORE_INIT) ? key_sbox : enc_sbox;

    assign ready_o        = ready_reg;
    assign result_o       = muxed_block;
    assign result_valid_o = result_valid_reg;

    //////////////////////////////
    // encdec mux
    //////////////////////////////

    always_comb begin
        if (enc_sel_reg) begin
            muxed_round = enc_round;
            muxed_block = enc_block;
            muxed_ready = enc_ready;
        end else begin
            muxed_round = dec_round;
            muxed_block = dec_block;
            muxed_ready = dec_ready;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_reg        <= aes_ctrl_pkg::CORE_IDLE;
            ready_reg        <= 1'b1;
            result_valid_reg <= 1'b0;
            enc_sel_reg      <= 1'b0;
        end else begin
            case (state_reg)
                aes_ctrl_pkg::CORE_IDLE: if (on_i) begin
                    state_reg        <= aes_ctrl_pkg::CORE_INIT;
                    ready_reg        <= 1'b0;
                    result_valid_reg <= 1'b0;
                    enc_sel_reg      <= req_i.encdec;
                end
                aes_ctrl_pkg::CORE_INIT: if (key_ready) begin
                    state_reg <= aes_ctrl_pkg::CORE_NEXT;  // engine started this edge
                end
                aes_ctrl_pkg::CORE_NEXT: if (muxed_ready) begin
                    state_reg        <= aes_ctrl_pkg::CORE_IDLE;
                    ready_reg        <= 1'b1;
                    result_valid_reg <= 1'b1;
                end
                default: state_reg <= aes_ctrl_pkg::CORE_IDLE;
            endcase
        end
    end

endmodule

// File: source/aes_ctrl_pkg.sv
package aes_ctrl_pkg;

    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_INIT,  // key expansion running
        CORE_NEXT   // selected round engine running
    } core_state_e;

    typedef enum logic [1:0] {
        RND_IDLE,
        RND_SUB,    // one word through the S-box per cycle
        RND_MIX     // remaining round steps in a single cycle
    } round_state_e;

    typedef enum logic {
        KEY_IDLE,
        KEY_GEN
    } key_state_e;

endpackage

// File: source/aes_decipher_block.sv
`include "aes_defines.svh"

module aes_decipher_block (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            next_i,
    output aes_pkg::round_t round_o,
    input  aes_pkg::block_t round_key_i,
    input  aes_pkg::block_t block_i,
    output aes_pkg::block_t new_block_o,
    output logic            ready_o
);

    localparam aes_pkg::round_t LAST_ROUND = aes_pkg::round_t'(`AES_NR);
    localparam logic [1:0]      LAST_WORD  = 2'(`AES_NWORDS - 1);

    aes_ctrl_pkg::round_state_e state_reg;
    aes_pkg::round_t            round_reg;   // counts down to 0
    logic [1:0]                 word_ctr;
    logic                       ready_reg;
    aes_pkg::block_t            block_reg;
    aes_pkg::block_t            keyed;
    aes_pkg::block_t            mixed;
    aes_pkg::word_t             inv_in;
    aes_pkg::word_t             inv_out;

    function automatic aes_pkg::block_t inv_shift_rows(input aes_pkg::block_t b);
        aes_pkg::word_t w0;
        aes_pkg::word_t w1;
        aes_pkg::word_t w2;
        aes_pkg::word_t w3;
        {w0, w1, w2, w3} = b;
        inv_shift_rows = {w0[31:24], w3[23:16], w2[15:8], w1[7:0],
                          w1[31:24], w0[23:16], w3[15:8], w2[7:0],
                          w2[31:24], w1[23:16], w0[15:8], w3[7:0],
                          w3[31:24], w2[23:16], w1[15:8], w0[7:0]};
    endfunction

    function automatic aes_pkg::word_t inv_mix_word(input aes_pkg::word_t w);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        {b0, b1, b2, b3} = w;
        inv_mix_word = {
            aes_pkg::gf_mul(b0, 4'he) ^ aes_pkg::gf_mul(b1, 4'hb) ^
            aes_pkg::gf_mul(b2, 4'hd) ^ aes_pkg::gf_mul(b3, 4'h9),
            aes_pkg::gf_mul(b0, 4'h9) ^ aes_pkg::gf_mul(b1, 4'he) ^
            aes_pkg::gf_mul(b2, 4'hb) ^ aes_pkg::gf_mul(b3, 4'hd),
            aes_pkg::gf_mul(b0, 4'hd) ^ aes_pkg::gf_mul(b1, 4'h9) ^
            aes_pkg::gf_mul(b2, 4'he) ^ aes_pkg::gf_mul(b3, 4'hb),
            aes_pkg::gf_mul(b0, 4'hb) ^ aes_pkg::gf_mul(b1, 4'hd) ^
            aes_pkg::gf_mul(b2, 4'h9) ^ aes_pkg::gf_mul(b3, 4'he)};
    endfunction

    aes_inv_sbox u_inv_sbox (
        .in_i  (inv_in),
        .out_o (inv_out)
    );

    assign inv_in      = block_reg[{~word_ctr, 5'b00000} +: 32];
    assign round_o     = round_reg;
    assign new_block_o = block_reg;
    assign ready_o     = ready_reg;

    // InvShiftRows of the following round is folded into this cycle
    always_comb begin
        keyed = block_reg ^ round_key_i;
        if (round_reg == '0) begin
            mixed = keyed;
        end else begin
            mixed = inv_shift_rows({inv_mix_word(keyed[127:96]), inv_mix_word(keyed[95:64]),
                                    inv_mix_word(keyed[63:32]), inv_mix_word(keyed[31:0])});
        end
    end

    //////////////////////////////
    // round sequencing
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_reg <= aes_ctrl_pkg::RND_IDLE;
            round_reg <= LAST_ROUND;  // first key needed is the last one expanded
            word_ctr  <= '0;
            ready_reg <= 1'b0;
        end else begin
            case (state_reg)
                aes_ctrl_pkg::RND_IDLE: if (next_i) begin
                    state_reg <= aes_ctrl_pkg::RND_SUB;
                    round_reg <= LAST_ROUND - 1'b1;
                    word_ctr  <= '0;
                    ready_reg <= 1'b0;
                end
                aes_ctrl_pkg::RND_SUB: begin
                    word_ctr <= word_ctr + 1'b1;
                    if (word_ctr == LAST_WORD) state_reg <= aes_ctrl_pkg::RND_MIX;
                end
                aes_ctrl_pkg::RND_MIX: if (round_reg == '0) begin
                    state_reg <= aes_ctrl_pkg::RND_IDLE;
                    round_reg <= LAST_ROUND;
                    ready_reg <= 1'b1;
                end else begin
                    state_reg <= aes_ctrl_pkg::RND_SUB;
                    round_reg <= round_reg - 1'b1;
                end
                default: state_reg <= aes_ctrl_pkg::RND_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_reg)
            aes_ctrl_pkg::RND_IDLE: if (next_i) block_reg <= inv_shift_rows(block_i ^ round_key_i);
            aes_ctrl_pkg::RND_SUB:  block_reg[{~word_ctr, 5'b00000} +: 32] <= inv_out;
            aes_ctrl_pkg::RND_MIX:  block_reg <= mixed;
            default: ;
        endcase
    end

endmodule

// File: source/aes_defines.svh
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// AES-128 geometry
`define AES_BLOCK_W 128
`define AES_KEY_W   128
`define AES_NR      10
`define AES_NWORDS  4

`endif

// File: source/aes_encipher_block.sv
`include "aes_defines.svh"

module aes_encipher_block (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            next_i,
    output aes_pkg::round_t round_o,
    input  aes_pkg::block_t round_key_i,
    output aes_pkg::word_t  sbox_o,
    input  aes_pkg::word_t  sbox_i,
    input  aes_pkg::block_t block_i,
    output aes_pkg::block_t new_block_o,
    output logic            ready_o
);

    localparam aes_pkg::round_t LAST_ROUND = aes_pkg::round_t'(`AES_NR);
    localparam logic [1:0]      LAST_WORD  = 2'(`AES_NWORDS - 1);

    aes_ctrl_pkg::round_state_e state_reg;
    aes_pkg::round_t            round_reg;
    logic [1:0]                 word_ctr;
    logic                       ready_reg;
    aes_pkg::block_t            block_reg;
    aes_pkg::block_t            mixed;

    function automatic aes_pkg::block_t shift_rows(input aes_pkg::block_t b);
        aes_pkg::word_t w0;
        aes_pkg::word_t w1;
        aes_pkg::word_t w2;
        aes_pkg::word_t w3;
        {w0, w1, w2, w3} = b;
        shift_rows = {w0[31:24], w1[23:16], w2[15:8], w3[7:0],
                      w1[31:24], w2[23:16], w3[15:8], w0[7:0],
                      w2[31:24], w3[23:16], w0[15:8], w1[7:0],
                      w3[31:24], w0[23:16], w1[15:8], w2[7:0]};
    endfunction

    function automatic aes_pkg::word_t mix_word(input aes_pkg::word_t w);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        {b0, b1, b2, b3} = w;
        mix_word = {aes_pkg::gf_mul(b0, 4'h2) ^ aes_pkg::gf_mul(b1, 4'h3) ^ b2 ^ b3,
                    b0 ^ aes_pkg::gf_mul(b1, 4'h2) ^ aes_pkg::gf_mul(b2, 4'h3) ^ b3,
                    b0 ^ b1 ^ aes_pkg::gf_mul(b2, 4'h2) ^ aes_pkg::gf_mul(b3, 4'h3),
                    aes_pkg::gf_mul(b0, 4'h3) ^ b1 ^ b2 ^ aes_pkg::gf_mul(b3, 4'h2)};
    endfunction

    assign round_o     = round_reg;
    assign sbox_o      = block_reg[{~word_ctr, 5'b00000} +: 32];  // word 0 is the top column
    assign new_block_o = block_reg;
    assign ready_o     = ready_reg;

    always_comb begin
        mixed = shift_rows(block_reg);
        if (round_reg != LAST_ROUND) begin
            mixed = {mix_word(mixed[127:96]), mix_word(mixed[95:64]),
                     mix_word(mixed[63:32]), mix_word(mixed[31:0])};
        end
        mixed = mixed ^ round_key_i;
    end

    //////////////////////////////
    // round sequencing
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_reg <= aes_ctrl_pkg::RND_IDLE;
            round_reg <= '0;
            word_ctr  <= '0;
            ready_reg <= 1'b0;
        end else begin
            case (state_reg)
                aes_ctrl_pkg::RND_IDLE: if (next_i) begin
                    state_reg <= aes_ctrl_pkg::RND_SUB;
                    round_reg <= aes_pkg::round_t'(1);
                    word_ctr  <= '0;
                    ready_reg <= 1'b0;
                end
                aes_ctrl_pkg::RND_SUB: begin
                    word_ctr <= word_ctr + 1'b1;
                    if (word_ctr == LAST_WORD) state_reg <= aes_ctrl_pkg::RND_MIX;
                end
                aes_ctrl_pkg::RND_MIX: if (round_reg == LAST_ROUND) begin
                    state_reg <= aes_ctrl_pkg::RND_IDLE;
                    round_reg <= '0;  // round 0 key for the next block
                    ready_reg <= 1'b1;
                end else begin
                    state_reg <= aes_ctrl_pkg::RND_SUB;
                    round_reg <= round_reg + 1'b1;
                end
                default: state_reg <= aes_ctrl_pkg::RND_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_reg)
            aes_ctrl_pkg::RND_IDLE: if (next_i) block_reg <= block_i ^ round_key_i;
            aes_ctrl_pkg::RND_SUB:  block_reg[{~word_ctr, 5'b00000} +: 32] <= sbox_i;
            aes_ctrl_pkg::RND_MIX:  block_reg <= mixed;
            default: ;
        endcase
    end

endmodule

// File: source/aes_inv_sbox.sv
module aes_inv_sbox (
    input  aes_pkg::word_t in_i,
    output aes_pkg::word_t out_o
);

    localparam logic [2047:0] TABLE = {  // entry 0 in the top byte
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    function automatic logic [7:0] inv_sub(input logic [7:0] b);
        inv_sub = TABLE[{~b, 3'b000} +: 8];
    endfunction

    assign out_o = {inv_sub(in_i[31:24]), inv_sub(in_i[23:16]),
                    inv_sub(in_i[15:8]), inv_sub(in_i[7:0])};

endmodule

// File: source/aes_key_mem.sv
`include "aes_defines.svh"

module aes_key_mem (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  aes_pkg::key_t   key_i,
    input  logic            init_i,
    input  aes_pkg::round_t round_i,
    output aes_pkg::block_t round_key_o,
    output logic            ready_o,
    output aes_pkg::word_t  sbox_o,
    input  aes_pkg::word_t  sbox_i
);

    localparam aes_pkg::round_t LAST_ROUND = aes_pkg::round_t'(`AES_NR);

    aes_ctrl_pkg::key_state_e state_reg;
    aes_pkg::round_t          round_ctr;   // slot written this cycle
    logic [7:0]               rcon;
    logic                     ready_reg;

    aes_pkg::block_t key_mem [0:`AES_NR];
    aes_pkg::block_t prev_key;
    aes_pkg::block_t new_key;
    aes_pkg::word_t  temp;
    aes_pkg::word_t  w0;
    aes_pkg::word_t  w1;
    aes_pkg::word_t  w2;
    aes_pkg::word_t  w3;

    assign sbox_o      = {prev_key[23:0], prev_key[31:24]};  // RotWord of the last word
    assign round_key_o = key_mem[round_i];
    assign ready_o     = ready_reg;

    always_comb begin
        temp    = sbox_i ^ {rcon, 24'h000000};
        w0      = prev_key[127:96] ^ temp;
        w1      = prev_key[95:64] ^ w0;
        w2      = prev_key[63:32] ^ w1;
        w3      = prev_key[31:0] ^ w2;
        new_key = {w0, w1, w2, w3};
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_reg <= aes_ctrl_pkg::KEY_IDLE;
            round_ctr <= '0;
            rcon      <= 8'h01;
            ready_reg <= 1'b0;
        end else if (init_i) begin
            state_reg <= aes_ctrl_pkg::KEY_GEN;
            round_ctr <= aes_pkg::round_t'(1);
            rcon      <= 8'h01;
            ready_reg <= 1'b0;
        end else if (state_reg == aes_ctrl_pkg::KEY_GEN) begin
            round_ctr <= round_ctr + 1'b1;
            rcon      <= aes_pkg::gf_mul(rcon, 4'h2);
            if (round_ctr == LAST_ROUND) begin
                state_reg <= aes_ctrl_pkg::KEY_IDLE;
                ready_reg <= 1'b1;  // all eleven keys stored
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (init_i) begin
            key_mem[0] <= key_i;
            prev_key   <= key_i;
        end else if (state_reg == aes_ctrl_pkg::KEY_GEN) begin
            key_mem[round_ctr] <= new_key;
            prev_key           <= new_key;
        end
    end

endmodule

// File: source/aes_pkg.sv
`include "aes_defines.svh"

package aes_pkg;

    typedef logic [`AES_BLOCK_W-1:0] block_t;  // byte 0 of the state sits in the top bits
    typedef logic [`AES_KEY_W-1:0]   key_t;
    typedef logic [31:0]             word_t;   // one state column
    typedef logic [3:0]              round_t;

    typedef struct packed {
        logic   encdec;  // 1 enciphers, 0 deciphers
        key_t   key;
        block_t block;
    } aes_req_t;

    // GF(2^8) product of b and a 4-bit constant, reduced by the AES polynomial
    function automatic logic [7:0] gf_mul(input logic [7:0] b, input logic [3:0] m);
        logic [7:0] b2;
        logic [7:0] b4;
        logic [7:0] b8;
        b2 = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
        b4 = {b2[6:0], 1'b0} ^ (b2[7] ? 8'h1b : 8'h00);
        b8 = {b4[6:0], 1'b0} ^ (b4[7] ? 8'h1b : 8'h00);
        gf_mul = (m[0] ? b : 8'h00) ^ (m[1] ? b2 : 8'h00) ^
                 (m[2] ? b4 : 8'h00) ^ (m[3] ? b8 : 8'h00);
    endfunction

endpackage

// File: source/aes_sbox.sv
module aes_sbox (
    input  aes_pkg::word_t in_i,
    output aes_pkg::word_t out_o
);

    localparam logic [2047:0] TABLE = {  // entry 0 in the top byte
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] sub(input logic [7:0] b);
        sub = TABLE[{~b, 3'b000} +: 8];
    endfunction

    assign out_o = {sub(in_i[31:24]), sub(in_i[23:16]), sub(in_i[15:8]), sub(in_i[7:0])};

endmodule

// File: tests/aes_core_tb.sv
module aes_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF      = 4;
    localparam int CLK_PERIOD    = 2 * CLK_HALF;
    localparam int NUM_VEC       = 6;   // three encipher rows, three decipher rows
    localparam int NUM_RAND      = 8;
    localparam int NUM_OPS       = NUM_VEC + 1 + 2 * NUM_RAND;
    localparam int OP_CYCLES     = 100;
    localparam int WATCHDOG_NS   = NUM_OPS * OP_CYCLES * CLK_PERIOD;
    localparam int HOLD_CYCLES   = 5;
    localparam int unsigned SEED = 80618;

    // one known-answer row, request followed by the block it must produce
    typedef struct packed {
        aes_pkg::aes_req_t req;
        aes_pkg::block_t   expected;
    } vector_t;

    logic              clk_i;
    logic              rst_ni;
    aes_pkg::aes_req_t req_i;
    logic              on_i;
    logic              ready_o;
    aes_pkg::block_t   result_o;
    logic              result_valid_o;

    vector_t vectors [0:NUM_VEC-1];

    aes_core u_dut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_i          (req_i),
        .on_i           (on_i),
        .ready_o        (ready_o),
        .result_o       (result_o),
        .result_valid_o (result_valid_o)
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_block(input string name, input aes_pkg::block_t actual,
                               input aes_pkg::block_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                     $time, name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b",
                     $time, name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    // FIPS-197 appendix C.1 and appendix B, plus the first SP 800-38A ECB block
    task automatic fill_table();
        vectors[0] = {1'b1, 128'h000102030405060708090a0b0c0d0e0f,
                      128'h00112233445566778899aabbccddeeff,
                      128'h69c4e0d86a7b0430d8cdb78070b4c55a};
        vectors[1] = {1'b1, 128'h2b7e151628aed2a6abf7158809cf4f3c,
                      128'h3243f6a8885a308d313198a2e0370734,
                      128'h3925841d02dc09fbdc118597196a0b32};
        vectors[2] = {1'b1, 128'h2b7e151628aed2a6abf7158809cf4f3c,
                      128'h6bc1bee22e409f96e93d7e117393172a,
                      128'h3ad77bb40d7a3660a89ecaf32466ef97};
        vectors[3] = {1'b0, 128'h000102030405060708090a0b0c0d0e0f,
                      128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                      128'h00112233445566778899aabbccddeeff};
        vectors[4] = {1'b0, 128'h2b7e151628aed2a6abf7158809cf4f3c,
                      128'h3925841d02dc09fbdc118597196a0b32,
                      128'h3243f6a8885a308d313198a2e0370734};
        vectors[5] = {1'b0, 128'h2b7e151628aed2a6abf7158809cf4f3c,
                      128'h3ad77bb40d7a3660a89ecaf32466ef97,
                      128'h6bc1bee22e409f96e93d7e117393172a};
    endtask

    // returns on the rising edge that accepts the request
    task automatic start_op(input aes_pkg::aes_req_t req);
        @(negedge clk_i);
        while (ready_o !== 1'b1) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        req_i <= req;
        on_i  <= 1'b1;
        @(posedge clk_i);
        on_i  <= 1'b0;
    endtask

    task automatic wait_result(output aes_pkg::block_t result, output int cycles);
        cycles = 0;
        @(negedge clk_i);
        check_bit("result_valid_o", result_valid_o, 1'b0);  // cleared by the accepting edge
        while (result_valid_o !== 1'b1) begin
            check_bit("ready_o", ready_o, 1'b0);  // busy until the result shows up
            @(negedge clk_i);
            cycles++;
        end
        check_bit("ready_o", ready_o, 1'b1);
        result = result_o;
    endtask

    task automatic run_op(input aes_pkg::aes_req_t req, output aes_pkg::block_t result,
                          output int cycles);
        start_op(req);
        wait_result(result, cycles);
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin : main
        aes_pkg::aes_req_t req;
        aes_pkg::block_t   result;
        aes_pkg::block_t   cipher;
        aes_pkg::block_t   plain;
        aes_pkg::key_t     key;
        int                cycles;
        int                ref_cycles;

        clk_i  = 1'b0;
        rst_ni = 1'b0;
        on_i   = 1'b0;
        req_i  = '0;
        ref_cycles = 0;
        void'($urandom(SEED));
        fill_table();

        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_bit("ready_o", ready_o, 1'b1);
        check_bit("result_valid_o", result_valid_o, 1'b0);

        for (int i = 0; i < NUM_VEC; i++) begin
            run_op(vectors[i].req, result, cycles);
            check_block("result_o", result, vectors[i].expected);
            if (i == 1) begin
                ref_cycles = cycles;  // row 1 is replayed below with a stray start
            end
        end

        // a start pulse while busy must be ignored
        start_op(vectors[1].req);
        fork
            begin
                repeat (3) @(posedge clk_i);
                on_i <= 1'b1;
                @(posedge clk_i);
                on_i <= 1'b0;
            end
        join_none
        wait_result(result, cycles);
        check_block("result_o", result, vectors[1].expected);
        if (cycles != ref_cycles) begin
            $display("a start pulse while busy changed the latency from %0d to %0d cycles",
                     ref_cycles, cycles);
            $display("CHECKS FAILED");
            $fatal(1, "start pulse while busy was not ignored");
        end

        repeat (HOLD_CYCLES) begin
            @(negedge clk_i);
            check_bit("result_valid_o", result_valid_o, 1'b1);
            check_bit("ready_o", ready_o, 1'b1);
            check_block("result_o", result_o, vectors[1].expected);
        end

        // round trips with a fresh key every time
        for (int n = 0; n < NUM_RAND; n++) begin
            key   = {$urandom, $urandom, $urandom, $urandom};
            plain = {$urandom, $urandom, $urandom, $urandom};

            req.encdec = 1'b1;
            req.key    = key;
            req.block  = plain;
            run_op(req, cipher, cycles);

            req.encdec = 1'b0;
            req.block  = cipher;
            run_op(req, result, cycles);
            check_block("result_o", result, plain);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout after %0d ns: an operation never completed", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
